// File: bench/scene_painter_tb.sv
module scene_painter_tb;
	import miner_pkg::*;

	typedef struct packed {
		logic [2:0] cmd;	// Background, go, plot
		coord_t     pos;	// Claw column request
		logic [2:0] cmd2;	// Pulsed while busy
		int         pixels;	// Expected write count
		logic       rnd;	// Column from the LFSR
	} entry_t;

	localparam int NUM_ENTRIES = 12;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 10;	// Quiet window after reset
	localparam int ENTRY_SLACK = 20;	// Overhead allowed per entry
	localparam int QUIET_CYCLES = 4;
	localparam int BUSY_PULSE_CYC = 10;	// Second command lands mid-drawing

	localparam logic [2:0] C_NONE = 3'b000;
	localparam logic [2:0] C_BG = 3'b100;
	localparam logic [2:0] C_GO = 3'b010;
	localparam logic [2:0] C_PLOT = 3'b001;

	logic    clk = 1'b0;
	logic    arst_n;
	logic    plot;
	logic    background;
	logic    go;
	coord_t  position_in;
	coord_t  x;
	coord_t  y;
	colour_t colour;
	logic    write_en;
	logic    busy;
	logic    done;

	entry_t      stim [NUM_ENTRIES];
	logic [31:0] lfsr = 32'hd02c_9990;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests_failed = 0;
	int          total_writes = 0;
	int          pixel_sum = 0;

	scene_painter i_scene_painter (
		.clk(clk), .arst_n(arst_n),
		.plot(plot), .background(background), .go(go), .position_in(position_in),
		.x(x), .y(y), .colour(colour), .write_en(write_en), .busy(busy), .done(done)
	);

	always #5 clk = ~clk;	// 10 unit period

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// Galois, right shift
	endfunction

	task automatic next_position(output coord_t c);
		int i;
		for (i = 0; i < 9; i++) begin
			c[i] = lfsr[0];	// One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Priority background, go, plot
	function automatic draw_mode_e expected_mode(input logic [2:0] c);
		if (c[2]) begin
			return MODE_BG;
		end else if (c[1]) begin
			return MODE_ITEMS;
		end
		return MODE_CLAW;
	endfunction

	// Expected nth pixel of a drawing
	task automatic pixel_model(input draw_mode_e m, input coord_t claw_col, input int n,
		output coord_t ex, output coord_t ey, output colour_t ec);
		int it;
		int row;
		int col;
		logic border;
		it = n / CLAW_PIXELS;
		row = (n % CLAW_PIXELS) / SPRITE_SIZE;
		col = n % SPRITE_SIZE;
		border = (row == 0) || (row == SPRITE_SIZE - 1) || (col == 0) || (col == SPRITE_SIZE - 1);
		if (m == MODE_BG) begin
			ex = coord_t'(n % SCREEN_W);	// x fastest
			ey = coord_t'(n / SCREEN_W);
			ec = (ey < SKY_ROWS) ? COL_SKY : COL_EARTH;
		end else if (m == MODE_CLAW) begin
			ex = claw_col + coord_t'(col);
			ey = CLAW_Y + coord_t'(row);
			ec = COL_CLAW;
		end else begin
			ex = ITEM_X[it] + coord_t'(col);
			ey = ITEM_Y[it] + coord_t'(row);
			if (it < NUM_ITEMS / 2) begin
				ec = border ? COL_GOLD_EDGE : COL_GOLD;	// Gold first
			end else begin
				ec = border ? COL_STONE_EDGE : COL_STONE;
			end
		end
	endtask

	task automatic check_coord(input string what, input coord_t got, input coord_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_colour(input string what, input colour_t got, input colour_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic apply_cmd(input logic [2:0] c);
		background = c[2];
		go = c[1];
		plot = c[0];
	endtask

	task automatic check_quiet(input string what);
		check_flag({what, " write_en"}, write_en, 1'b0);
		check_flag({what, " busy"}, busy, 1'b0);
		check_flag({what, " done"}, done, 1'b0);
	endtask

	// One table entry, from command to quiet bus
	task automatic run_entry(input int idx);
		entry_t     e;
		draw_mode_e m;
		coord_t     clip;
		coord_t     ex;
		coord_t     ey;
		colour_t    ec;
		int         cyc;
		int         writes;
		int         err_start;
		int         last_cyc;
		logic       done_seen;
		e = stim[idx];
		m = expected_mode(e.cmd);
		clip = (e.pos > CLAW_X_MAX) ? CLAW_X_MAX : e.pos;	// Sprite stays on screen
		err_start = errors;
		cyc = 0;
		writes = 0;
		done_seen = 1'b0;
		last_cyc = e.pixels + 2;	// Last write and done together
		@(negedge clk);
		position_in = e.pos;
		apply_cmd(e.cmd);
		while (!done_seen && (cyc <= last_cyc + ENTRY_SLACK)) begin
			@(negedge clk);
			cyc++;
			check_flag("write_en", write_en, logic'((cyc >= 3) && (cyc <= last_cyc)));
			check_flag("busy", busy, logic'((cyc >= 2) && (cyc < last_cyc)));
			check_flag("done", done, logic'(cyc == last_cyc));
			if (write_en) begin
				pixel_model(m, clip, writes, ex, ey, ec);
				check_coord("x", x, ex);
				check_coord("y", y, ey);
				check_colour("colour", colour, ec);
				writes++;
			end
			done_seen = done;
			if (cyc == 1) begin
				apply_cmd(C_NONE);
				position_in = ~e.pos;	// Captured column must hold
			end
			if (cyc == BUSY_PULSE_CYC) begin
				apply_cmd(e.cmd2);
			end
			if (cyc == BUSY_PULSE_CYC + 1) begin
				apply_cmd(C_NONE);
			end
		end
		apply_cmd(C_NONE);
		if (!done_seen) begin
			errors++;
			$display("entry %0d: no done pulse within %0d cycles of the command", idx, cyc);
		end
		check_count("write count", writes, e.pixels);
		total_writes += writes;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			check_quiet("after done");	// Busy command must not start
		end
		if (errors != err_start) begin
			tests_failed++;
		end
		$display("entry %0d %s column %0d: %0d writes, %0d errors, %s", idx, m.name(), e.pos,
			writes, errors - err_start, (errors == err_start) ? "pass" : "fail");
	endtask

	initial begin
		int i;
		int err_start;
		arst_n = 1'b0;
		plot = 1'b0;
		background = 1'b0;
		go = 1'b0;
		position_in = '0;
		stim[0] = '{C_BG, 9'd0, C_NONE, BG_PIXELS, 1'b0};
		stim[1] = '{C_PLOT, 9'd0, C_GO, CLAW_PIXELS, 1'b0};
		stim[2] = '{C_PLOT, 9'd100, C_NONE, CLAW_PIXELS, 1'b0};
		stim[3] = '{C_PLOT, 9'd312, C_BG, CLAW_PIXELS, 1'b0};
		stim[4] = '{C_PLOT, 9'd400, C_NONE, CLAW_PIXELS, 1'b0};	// Clips
		stim[5] = '{C_PLOT, 9'd511, C_PLOT, CLAW_PIXELS, 1'b0};	// Clips
		stim[6] = '{C_GO, 9'd0, C_PLOT, ITEM_PIXELS, 1'b0};
		stim[7] = '{C_BG | C_GO | C_PLOT, 9'd37, C_GO, BG_PIXELS, 1'b0};	// All at once
		stim[8] = '{C_PLOT, 9'd0, C_NONE, CLAW_PIXELS, 1'b1};
		stim[9] = '{C_PLOT, 9'd0, C_GO, CLAW_PIXELS, 1'b1};
		stim[10] = '{C_PLOT, 9'd0, C_NONE, CLAW_PIXELS, 1'b1};
		stim[11] = '{C_GO | C_PLOT, 9'd200, C_BG, ITEM_PIXELS, 1'b0};	// Go beats plot
		for (i = 0; i < NUM_ENTRIES; i++) begin
			if (stim[i].rnd) begin
				next_position(stim[i].pos);
			end
			pixel_sum += stim[i].pixels;
		end
		cycle_limit = pixel_sum + ENTRY_SLACK * NUM_ENTRIES + RESET_CYCLES + IDLE_CYCLES;

		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		// Nothing moves without a command
		err_start = errors;
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_quiet("idle");
		end
		if (errors != err_start) begin
			tests_failed++;
		end
		$display("reset idle: %0d errors, %s", errors - err_start,
			(errors == err_start) ? "pass" : "fail");

		for (i = 0; i < NUM_ENTRIES; i++) begin
			run_entry(i);
		end
		check_count("total writes", total_writes, pixel_sum);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_ENTRIES + 1,
			tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
verilog/miner_pkg.sv
verilog/draw_counter.sv
verilog/view_fsm.sv
verilog/view_data.sv
verilog/scene_painter.sv
bench/scene_painter_tb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=scene_painter_tb

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f list.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: verilog/draw_counter.sv
module draw_counter (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  clear,		// Restart every count
	input  logic                  step_pixel,	// Next pixel or raster step
	input  logic                  step_item,	// Next item
	input  miner_pkg::draw_mode_e mode,
	output logic [2:0]            pix_row,
	output logic [2:0]            pix_col,
	output logic [2:0]            item,
	output miner_pkg::coord_t     ras_x,
	output miner_pkg::coord_t     ras_y,
	output logic                  last_pixel,	// Sprite at 7,7
	output logic                  last_raster,	// Raster at 319,239
	output logic                  last_item	// Eighth item
);
	import miner_pkg::*;

	logic [5:0] pix_cnt;	// Row in upper half, column in lower
	logic       row_end;	// Raster at right edge

	assign pix_row = pix_cnt[5:3];
	assign pix_col = pix_cnt[2:0];
	assign row_end = (ras_x == coord_t'(SCREEN_W - 1));

	// Sprite pixel and item counters
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt <= '0;
			item    <= '0;
		end else if (clear) begin
			pix_cnt <= '0;
			item    <= '0;
		end else if (step_item) begin
			pix_cnt <= '0;			// Fresh sprite
			item    <= item + 3'd1;
		end else if (step_pixel && (mode != MODE_BG)) begin
			pix_cnt <= pix_cnt + 6'd1;	// Row-major walk
		end
	end

	// Raster counters, x fastest
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ras_x <= '0;
			ras_y <= '0;
		end else if (clear) begin
			ras_x <= '0;
			ras_y <= '0;
		end else if (step_pixel && (mode == MODE_BG)) begin
			if (row_end) begin
				ras_x <= '0;
				ras_y <= last_raster ? '0 : ras_y + 9'd1;	// Wrap at frame end
			end else begin
				ras_x <= ras_x + 9'd1;
			end
		end
	end

	assign last_pixel = (pix_row == 3'(SPRITE_SIZE - 1)) && (pix_col == 3'(SPRITE_SIZE - 1));
	assign last_raster = row_end && (ras_y == coord_t'(SCREEN_H - 1));
	assign last_item = (item == 3'(NUM_ITEMS - 1));

	// Raster stays inside the frame
	a_raster_range: assert property (@(posedge clk) disable iff (!arst_n)
		(ras_x < SCREEN_W) && (ras_y < SCREEN_H));

	// FSM never asks for both steps at once
	a_one_step: assert property (@(posedge clk) disable iff (!arst_n)
		!(step_pixel && step_item));

endmodule

// File: verilog/miner_pkg.sv
package miner_pkg;

	// Shared screen and sprite types
	typedef logic [8:0]  coord_t;	// Screen column or row
	typedef logic [11:0] colour_t;	// Four bits per channel in RGB order

	typedef enum logic [1:0] {
		MODE_BG,	// Whole screen fill
		MODE_ITEMS,	// Treasure table walk
		MODE_CLAW	// Single claw sprite
	} draw_mode_e;

	// Frame buffer geometry
	localparam int SCREEN_W = 320;		// Columns
	localparam int SCREEN_H = 240;		// Rows
	localparam int SPRITE_SIZE = 8;		// Side of claw and items

	localparam coord_t SKY_ROWS = 9'd40;	// Ground line
	localparam coord_t CLAW_Y = 9'd24;	// Claw top row
	localparam coord_t CLAW_X_MAX = coord_t'(SCREEN_W - SPRITE_SIZE);	// Keeps sprite on screen

	localparam int NUM_ITEMS = 8;		// Index bit 2 marks a stone

	// Item top-left corners, gold first then stones
	localparam coord_t ITEM_X [NUM_ITEMS] = '{
		9'd40,		// Gold 0
		9'd128,		// Gold 1
		9'd200,		// Gold 2
		9'd272,		// Gold 3
		9'd24,		// Stone 4
		9'd96,		// Stone 5
		9'd168,		// Stone 6
		9'd240		// Stone 7
	};

	localparam coord_t ITEM_Y [NUM_ITEMS] = '{
		9'd96,
		9'd160,
		9'd72,
		9'd200,
		9'd216,
		9'd128,
		9'd184,
		9'd56		// Still below the ground line
	};

	// Palette
	localparam colour_t COL_SKY = 12'h6AF;
	localparam colour_t COL_EARTH = 12'h742;
	localparam colour_t COL_CLAW = 12'hCCC;
	localparam colour_t COL_GOLD = 12'hFD0;
	localparam colour_t COL_GOLD_EDGE = 12'hA80;	// Darker border
	localparam colour_t COL_STONE = 12'h888;
	localparam colour_t COL_STONE_EDGE = 12'h444;	// Darker border

	// Pixel counts per drawing
	localparam int BG_PIXELS = SCREEN_W * SCREEN_H;			// 76800
	localparam int CLAW_PIXELS = SPRITE_SIZE * SPRITE_SIZE;		// 64
	localparam int ITEM_PIXELS = NUM_ITEMS * CLAW_PIXELS;		// 512

endpackage

// File: verilog/scene_painter.sv
module scene_painter (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               plot,		// Draw claw
	input  logic               background,	// Paint sky and earth
	input  logic               go,		// Draw treasure
	input  miner_pkg::coord_t  position_in,	// Claw column
	output miner_pkg::coord_t  x,
	output miner_pkg::coord_t  y,
	output miner_pkg::colour_t colour,
	output logic               write_en,	// Frame buffer write
	output logic               busy,
	output logic               done
);
	import miner_pkg::*;

	draw_mode_e mode;
	logic       clear;
	logic       step_pixel;
	logic       step_item;
	logic       load;
	logic       paint;
	logic [2:0] pix_row;
	logic [2:0] pix_col;
	logic [2:0] item;
	coord_t     ras_x;
	coord_t     ras_y;
	logic       last_pixel;
	logic       last_raster;
	logic       last_item;

	// Command sequencer
	view_fsm i_view_fsm (
		.clk(clk), .arst_n(arst_n),
		.plot(plot), .background(background), .go(go),
		.last_pixel(last_pixel), .last_raster(last_raster), .last_item(last_item),
		.mode(mode), .clear(clear), .step_pixel(step_pixel), .step_item(step_item),
		.load(load), .paint(paint), .busy(busy), .done(done)
	);

	// Pixel, raster and item walk
	draw_counter i_draw_counter (
		.clk(clk), .arst_n(arst_n),
		.clear(clear), .step_pixel(step_pixel), .step_item(step_item), .mode(mode),
		.pix_row(pix_row), .pix_col(pix_col), .item(item), .ras_x(ras_x), .ras_y(ras_y),
		.last_pixel(last_pixel), .last_raster(last_raster), .last_item(last_item)
	);

	// Address and colour registers
	view_data i_view_data (
		.clk(clk), .arst_n(arst_n),
		.load(load), .paint(paint), .mode(mode), .position_in(position_in),
		.pix_row(pix_row), .pix_col(pix_col), .item(item), .ras_x(ras_x), .ras_y(ras_y),
		.x(x), .y(y), .colour(colour), .write_en(write_en)
	);

endmodule

// File: verilog/view_data.sv
module view_data (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  load,		// Accept pulse
	input  logic                  paint,	// Address valid this cycle
	input  miner_pkg::draw_mode_e mode,
	input  miner_pkg::coord_t     position_in,	// Requested claw column
	input  logic [2:0]            pix_row,
	input  logic [2:0]            pix_col,
	input  logic [2:0]            item,
	input  miner_pkg::coord_t     ras_x,
	input  miner_pkg::coord_t     ras_y,
	output miner_pkg::coord_t     x,
	output miner_pkg::coord_t     y,
	output miner_pkg::colour_t    colour,
	output logic                  write_en	// One pulse per pixel
);
	import miner_pkg::*;

	coord_t  claw_x;	// Clipped claw column
	coord_t  base_x;	// Sprite corner or raster point
	coord_t  base_y;
	coord_t  off_x;		// Offset inside sprite
	coord_t  off_y;
	colour_t pix_colour;
	logic    on_edge;	// Border pixel of an item

	// Claw column captured at accept
	always_ff @(posedge clk) begin
		if (load) begin
			claw_x <= (position_in > CLAW_X_MAX) ? CLAW_X_MAX : position_in;
		end
	end

	// Base corner by mode
	always_comb begin
		case (mode)
			MODE_ITEMS: begin
				base_x = ITEM_X[item];
				base_y = ITEM_Y[item];
			end
			MODE_CLAW: begin
				base_x = claw_x;
				base_y = CLAW_Y;
			end
			default: begin
				base_x = ras_x;	// Raster gives the address directly
				base_y = ras_y;
			end
		endcase
	end

	// No sprite offset in background mode
	assign off_x = (mode == MODE_BG) ? '0 : coord_t'(pix_col);
	assign off_y = (mode == MODE_BG) ? '0 : coord_t'(pix_row);

	assign on_edge = (pix_row == 3'd0) || (pix_row == 3'(SPRITE_SIZE - 1))
		|| (pix_col == 3'd0) || (pix_col == 3'(SPRITE_SIZE - 1));

	// Colour pick
	always_comb begin
		case (mode)
			MODE_BG: begin
				pix_colour = (ras_y < SKY_ROWS) ? COL_SKY : COL_EARTH;
			end
			MODE_CLAW: begin
				pix_colour = COL_CLAW;
			end
			default: begin
				if (item[2]) begin
					pix_colour = on_edge ? COL_STONE_EDGE : COL_STONE;	// Stones 4 to 7
				end else begin
					pix_colour = on_edge ? COL_GOLD_EDGE : COL_GOLD;
				end
			end
		endcase
	end

	// Pixel payload
	always_ff @(posedge clk) begin
		if (paint) begin
			x      <= base_x + off_x;
			y      <= base_y + off_y;
			colour <= pix_colour;
		end
	end

	// Write strobe trails paint by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			write_en <= 1'b0;
		end else begin
			write_en <= paint;
		end
	end

	// Counters and clipping keep every write on screen
	a_on_screen: assert property (@(posedge clk) disable iff (!arst_n)
		write_en |-> (x < SCREEN_W) && (y < SCREEN_H));

endmodule

// File: verilog/view_fsm.sv
module view_fsm (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  plot,		// Claw command
	input  logic                  background,	// Screen fill command
	input  logic                  go,		// Item table command
	input  logic                  last_pixel,
	input  logic                  last_raster,
	input  logic                  last_item,
	output miner_pkg::draw_mode_e mode,		// Drawing in progress
	output logic                  clear,
	output logic                  step_pixel,
	output logic                  step_item,
	output logic                  load,		// Accept pulse
	output logic                  paint,	// Valid pixel address
	output logic                  busy,
	output logic                  done
);
	import miner_pkg::*;

	// One-hot state flops, IDLE when none is set
	logic st_start;		// Counter clear cycle
	logic st_draw;		// One pixel per cycle
	logic st_finish;	// Done cycle
	logic st_idle;

	logic       cmd_any;	// Some command raised
	logic       accept;
	logic       draw_end;	// Final pixel of the drawing
	draw_mode_e cmd_mode;	// Decoded by priority

	assign st_idle = !(st_start || st_draw || st_finish);
	assign cmd_any = background || go || plot;
	assign accept = st_idle && cmd_any;	// Busy commands are dropped

	// Background wins, then go, then plot
	always_comb begin
		if (background) begin
			cmd_mode = MODE_BG;
		end else if (go) begin
			cmd_mode = MODE_ITEMS;
		end else begin
			cmd_mode = MODE_CLAW;
		end
	end

	// End of drawing per mode
	always_comb begin
		case (mode)
			MODE_BG:    draw_end = last_raster;
			MODE_ITEMS: draw_end = last_pixel && last_item;
			default:    draw_end = last_pixel;	// Claw is one sprite
		endcase
	end

	// State sequencing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st_start  <= 1'b0;
			st_draw   <= 1'b0;
			st_finish <= 1'b0;
		end else begin
			st_start  <= accept;		// IDLE to START
			st_finish <= st_draw && draw_end;	// DRAW to FINISH
			if (st_start) begin
				st_draw <= 1'b1;	// START to DRAW
			end else if (draw_end) begin
				st_draw <= 1'b0;
			end
		end
	end

	// Mode held for the whole drawing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= MODE_BG;
		end else if (accept) begin
			mode <= cmd_mode;
		end
	end

	assign load = accept;		// Data path grabs position_in
	assign clear = st_start;
	assign paint = st_draw;

	// Jump to next item instead of wrapping the sprite
	assign step_item = paint && (mode == MODE_ITEMS) && last_pixel && !last_item;
	assign step_pixel = paint && !step_item && !draw_end;	// Hold on final pixel

	assign busy = st_draw;		// Rises one edge after accept
	assign done = st_finish;	// Same edge as last write_en

	// At most one state flop set
	a_state_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({st_start, st_draw, st_finish}));

	// Single-cycle done
	a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done);

endmodule
